// ==== include/u2_ctrl_params.svh ====
// Control plane sizing for the board control core
// Bus widths, interrupt and LED counts, control word widths

`ifndef U2_CTRL_PARAMS_SVH
`define U2_CTRL_PARAMS_SVH

// Settings bus
`define SET_ADDR_W 8
`define SET_DATA_W 32

// Interrupt lines into the controller
`define IRQ_W 16

// Front panel
`define LED_W 8
`define RB_ADDR_W 4

// Board control words
`define CLK_CTRL_W 5
`define SER_CTRL_W 4
`define ADC_CTRL_W 4

`endif

// ==== hw/u2_ctrl_pkg.sv ====
// Shared types for the board control core
// Settings register map and readback word selects

`include "u2_ctrl_params.svh"

package u2_ctrl_pkg;

   // Settings bus register map
   typedef enum logic [`SET_ADDR_W-1:0] {
      SR_CLK       = 8'd0,
      SR_SER       = 8'd1,
      SR_ADC       = 8'd2,
      SR_LED       = 8'd3,
      SR_PHY       = 8'd4,
      SR_LED_SRC   = 8'd8,
      SR_IRQ_MASK  = 8'd9,
      SR_IRQ_CLEAR = 8'd10
   } set_addr_e;

   // Readback word selects
   // low selects mirror the settings map
   typedef enum logic [`RB_ADDR_W-1:0] {
      RB_CLK      = 4'd0,
      RB_SER      = 4'd1,
      RB_ADC      = 4'd2,
      RB_LED_SW   = 4'd3,
      RB_PHY      = 4'd4,
      RB_LED_SRC  = 4'd8,
      RB_IRQ_MASK = 4'd9,
      RB_IRQ_PEND = 4'd10,
      RB_SYS      = 4'd11
   } rb_addr_e;

endpackage

// ==== hw/setting_bank.sv ====
// Board control settings registers
// Loads clock, SERDES, ADC, PHY and LED control words from the settings bus

`timescale 1ns/1ns

`include "u2_ctrl_params.svh"

module setting_bank import u2_ctrl_pkg::*; (
   input  logic                   dsp_clk,
   input  logic                   arst_n_i,

   // Settings bus
   input  logic                   set_stb_i,
   input  logic [`SET_ADDR_W-1:0] set_addr_i,
   input  logic [`SET_DATA_W-1:0] set_data_i,

   // Control words
   output logic [`CLK_CTRL_W-1:0] clk_ctrl_o,
   output logic [`SER_CTRL_W-1:0] ser_ctrl_o,
   output logic [`ADC_CTRL_W-1:0] adc_ctrl_o,
   output logic                   phy_reset_o,
   output logic [`LED_W-1:0]      led_sw_o,
   output logic [`LED_W-1:0]      led_src_o
);

   ////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////

   // One register per owned address
   // Each takes the low bits of the data word
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         clk_ctrl_o  <= '0;
         ser_ctrl_o  <= '0;
         adc_ctrl_o  <= '0;
         phy_reset_o <= 1'b0;
         led_sw_o    <= '0;
         led_src_o   <= '0;
      end else if (set_stb_i) begin
         case (set_addr_i)
            SR_CLK: begin
               clk_ctrl_o <= set_data_i[`CLK_CTRL_W-1:0];
            end
            SR_SER: begin
               ser_ctrl_o <= set_data_i[`SER_CTRL_W-1:0];
            end
            SR_ADC: begin
               adc_ctrl_o <= set_data_i[`ADC_CTRL_W-1:0];
            end
            SR_LED: begin
               led_sw_o <= set_data_i[`LED_W-1:0];
            end
            SR_PHY: begin
               phy_reset_o <= set_data_i[0];
            end
            // Select bit 1 hands the LED to hardware
            SR_LED_SRC: begin
               led_src_o <= set_data_i[`LED_W-1:0];
            end
            // Interrupt and unmapped addresses belong elsewhere
            default: begin
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // A strobed write needs a resolved address
   a_set_addr_known: assert property (
      @(posedge dsp_clk) disable iff (!arst_n_i)
      set_stb_i |-> !$isunknown(set_addr_i)
   ) else $error("setting_bank: unknown settings address on strobe");

endmodule

// ==== hw/irq_controller.sv ====
// Interrupt controller
// Latches rising edges into pending bits and gates them by mask into one interrupt

`timescale 1ns/1ns

`include "u2_ctrl_params.svh"

module irq_controller import u2_ctrl_pkg::*; (
   input  logic                   dsp_clk,
   input  logic                   arst_n_i,

   // Settings bus
   input  logic                   set_stb_i,
   input  logic [`SET_ADDR_W-1:0] set_addr_i,
   input  logic [`SET_DATA_W-1:0] set_data_i,

   // Interrupt sources
   input  logic [`IRQ_W-1:0]      irq_i,

   output logic [`IRQ_W-1:0]      irq_mask_o,
   output logic [`IRQ_W-1:0]      irq_pend_o,
   output logic                   proc_int_o
);

   logic [`IRQ_W-1:0] irq_prev;
   logic [`IRQ_W-1:0] irq_rise;
   logic [`IRQ_W-1:0] clr_bits;
   logic [`IRQ_W-1:0] pend_kept;
   logic              mask_wr;

   // Edge detect against last sample
   assign irq_rise = irq_i & ~irq_prev;

   // Write one to clear
   assign clr_bits  = (set_stb_i && (set_addr_i == SR_IRQ_CLEAR)) ?
                      set_data_i[`IRQ_W-1:0] : '0;
   assign pend_kept = irq_pend_o & ~clr_bits;
   assign mask_wr   = set_stb_i && (set_addr_i == SR_IRQ_MASK);

   ////////////////////////////////////////
   // Pending, mask and interrupt
   ////////////////////////////////////////

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         irq_prev   <= '0;
         irq_pend_o <= '0;
         irq_mask_o <= '0;
         proc_int_o <= 1'b0;
      end else begin
         irq_prev <= irq_i;
         // New edge wins over a clear of the same bit
         irq_pend_o <= pend_kept | irq_rise;
         if (mask_wr) begin
            irq_mask_o <= set_data_i[`IRQ_W-1:0];
         end
         // Clear takes effect here at once, new edges show a cycle later
         proc_int_o <= |(pend_kept & irq_mask_o);
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Interrupt only follows an unmasked pending bit
   a_int_has_source: assert property (
      @(posedge dsp_clk) disable iff (!arst_n_i)
      proc_int_o |-> $past(|(irq_pend_o & irq_mask_o))
   ) else $error("irq_controller: interrupt without unmasked pending bit");

endmodule

// ==== hw/front_panel_status.sv ====
// Front panel status
// Merges software and hardware LEDs and serves the registered readback port

`timescale 1ns/1ns

`include "u2_ctrl_params.svh"

module front_panel_status import u2_ctrl_pkg::*; (
   input  logic                   dsp_clk,
   input  logic                   arst_n_i,

   // Settings register contents
   input  logic [`CLK_CTRL_W-1:0] clk_ctrl_i,
   input  logic [`SER_CTRL_W-1:0] ser_ctrl_i,
   input  logic [`ADC_CTRL_W-1:0] adc_ctrl_i,
   input  logic                   phy_reset_i,
   input  logic [`LED_W-1:0]      led_sw_i,
   input  logic [`LED_W-1:0]      led_src_i,

   // Interrupt state
   input  logic [`IRQ_W-1:0]      irq_mask_i,
   input  logic [`IRQ_W-1:0]      irq_pend_i,

   // Board status
   input  logic                   clk_status_i,
   input  logic                   serdes_link_up_i,
   input  logic                   sim_mode_i,
   input  logic [3:0]             clock_divider_i,

   input  logic [`RB_ADDR_W-1:0]  rb_addr_i,
   output logic [`LED_W-1:0]      leds_o,
   output logic [`SET_DATA_W-1:0] rb_data_o
);

   logic [1:0]        hw_stat_r;
   logic [`LED_W-1:0] led_hw;

   // Clock status on bit 1, link on bit 0
   assign led_hw = {{(`LED_W-2){1'b0}}, hw_stat_r};

   ////////////////////////////////////////
   // LED merge and readback
   ////////////////////////////////////////

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         hw_stat_r <= '0;
         leds_o    <= '0;
         rb_data_o <= '0;
      end else begin
         hw_stat_r <= {clk_status_i, serdes_link_up_i};
         leds_o    <= (led_src_i & led_hw) | (~led_src_i & led_sw_i);
         case (rb_addr_i)
            RB_CLK:      rb_data_o <= `SET_DATA_W'(clk_ctrl_i);
            RB_SER:      rb_data_o <= `SET_DATA_W'(ser_ctrl_i);
            RB_ADC:      rb_data_o <= `SET_DATA_W'(adc_ctrl_i);
            RB_LED_SW:   rb_data_o <= `SET_DATA_W'(led_sw_i);
            RB_PHY:      rb_data_o <= `SET_DATA_W'(phy_reset_i);
            RB_LED_SRC:  rb_data_o <= `SET_DATA_W'(led_src_i);
            RB_IRQ_MASK: rb_data_o <= `SET_DATA_W'(irq_mask_i);
            RB_IRQ_PEND: rb_data_o <= `SET_DATA_W'(irq_pend_i);
            RB_SYS:      rb_data_o <= {sim_mode_i, 27'b0, clock_divider_i};
            default:     rb_data_o <= '0;
         endcase
      end
   end

   // Holes in the readback map read as zero
   a_rb_unlisted_zero: assert property (
      @(posedge dsp_clk) disable iff (!arst_n_i)
      !(rb_addr_i inside {RB_CLK, RB_SER, RB_ADC, RB_LED_SW, RB_PHY,
                          RB_LED_SRC, RB_IRQ_MASK, RB_IRQ_PEND, RB_SYS})
      |=> (rb_data_o == '0)
   ) else $error("front_panel_status: unlisted readback address gave data");

endmodule

// ==== hw/u2_ctrl_top.sv ====
// Board control plane top
// Settings registers, interrupt controller and status readback wired to the pins

`timescale 1ns/1ns

`include "u2_ctrl_params.svh"

module u2_ctrl_top import u2_ctrl_pkg::*; (
   input  logic                   dsp_clk,
   input  logic                   arst_n_i,
   input  logic                   set_stb_i,
   input  logic [`SET_ADDR_W-1:0] set_addr_i,
   input  logic [`SET_DATA_W-1:0] set_data_i,
   input  logic [`IRQ_W-1:0]      irq_i,
   input  logic                   clk_status_i,
   input  logic                   serdes_link_up_i,
   input  logic                   sim_mode_i,
   input  logic [3:0]             clock_divider_i,
   input  logic [`RB_ADDR_W-1:0]  rb_addr_i,

   // Clock generator
   output logic                   clock_ready_o,
   output logic [1:0]             clk_en_o,
   output logic [1:0]             clk_sel_o,

   // SERDES and ADC enables
   output logic                   ser_enable_o,
   output logic                   ser_prbsen_o,
   output logic                   ser_loopen_o,
   output logic                   ser_rx_en_o,
   output logic                   adc_oe_a_o,
   output logic                   adc_on_a_o,
   output logic                   adc_oe_b_o,
   output logic                   adc_on_b_o,

   output logic                   phy_resetn_o,
   output logic [`LED_W-1:0]      leds_o,
   output logic                   proc_int_o,
   output logic [`SET_DATA_W-1:0] rb_data_o
);

   logic [`CLK_CTRL_W-1:0] clk_ctrl;
   logic [`SER_CTRL_W-1:0] ser_ctrl;
   logic [`ADC_CTRL_W-1:0] adc_ctrl;
   logic                   phy_reset;
   logic [`LED_W-1:0]      led_sw;
   logic [`LED_W-1:0]      led_src;
   logic [`IRQ_W-1:0]      irq_mask;
   logic [`IRQ_W-1:0]      irq_pend;

   ////////////////////////////////////////
   // Pin mapping
   ////////////////////////////////////////

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clk_ctrl;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = ser_ctrl;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_ctrl;
   // PHY runs while the register is clear
   assign phy_resetn_o = ~phy_reset;

   setting_bank i_setting_bank (
      .dsp_clk     (dsp_clk),
      .arst_n_i    (arst_n_i),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .clk_ctrl_o  (clk_ctrl),
      .ser_ctrl_o  (ser_ctrl),
      .adc_ctrl_o  (adc_ctrl),
      .phy_reset_o (phy_reset),
      .led_sw_o    (led_sw),
      .led_src_o   (led_src)
   );

   irq_controller i_irq_controller (
      .dsp_clk    (dsp_clk),
      .arst_n_i   (arst_n_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .irq_i      (irq_i),
      .irq_mask_o (irq_mask),
      .irq_pend_o (irq_pend),
      .proc_int_o (proc_int_o)
   );

   front_panel_status i_front_panel_status (
      .dsp_clk          (dsp_clk),
      .arst_n_i         (arst_n_i),
      .clk_ctrl_i       (clk_ctrl),
      .ser_ctrl_i       (ser_ctrl),
      .adc_ctrl_i       (adc_ctrl),
      .phy_reset_i      (phy_reset),
      .led_sw_i         (led_sw),
      .led_src_i        (led_src),
      .irq_mask_i       (irq_mask),
      .irq_pend_i       (irq_pend),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .sim_mode_i       (sim_mode_i),
      .clock_divider_i  (clock_divider_i),
      .rb_addr_i        (rb_addr_i),
      .leds_o           (leds_o),
      .rb_data_o        (rb_data_o)
   );

   // Clock word write reaches readback two cycles later
   a_clk_write_readback: assert property (
      @(posedge dsp_clk) disable iff (!arst_n_i)
      (set_stb_i && (set_addr_i == SR_CLK)) ##1 (rb_addr_i == RB_CLK)
      |=> (rb_data_o == `SET_DATA_W'($past(set_data_i[`CLK_CTRL_W-1:0], 2)))
   ) else $error("u2_ctrl_top: clock word readback mismatch");

endmodule

// ==== dv/u2_ctrl_tb.sv ====
// Testbench for the board control plane
// Applies a table of settings writes, interrupt levels and readbacks and checks the pins

`timescale 1ns/1ns

`include "u2_ctrl_params.svh"

module u2_ctrl_tb import u2_ctrl_pkg::*; ();

   // Row operations
   localparam logic [1:0] OP_IDLE = 2'd0;
   localparam logic [1:0] OP_WR   = 2'd1;
   localparam logic [1:0] OP_IRQ  = 2'd2;
   localparam logic [1:0] OP_RD   = 2'd3;

   // Output observed at the end of a row
   localparam logic [1:0] W_PINS = 2'd0;
   localparam logic [1:0] W_LEDS = 2'd1;
   localparam logic [1:0] W_INT  = 2'd2;
   localparam logic [1:0] W_RB   = 2'd3;

   localparam int MAX_ROWS = 64;

   logic                   dsp_clk;
   logic                   arst_n_i;
   logic                   set_stb_i;
   logic [`SET_ADDR_W-1:0] set_addr_i;
   logic [`SET_DATA_W-1:0] set_data_i;
   logic [`IRQ_W-1:0]      irq_i;
   logic                   clk_status_i;
   logic                   serdes_link_up_i;
   logic                   sim_mode_i;
   logic [3:0]             clock_divider_i;
   logic [`RB_ADDR_W-1:0]  rb_addr_i;
   logic                   clock_ready_o;
   logic [1:0]             clk_en_o;
   logic [1:0]             clk_sel_o;
   logic                   ser_enable_o;
   logic                   ser_prbsen_o;
   logic                   ser_loopen_o;
   logic                   ser_rx_en_o;
   logic                   adc_oe_a_o;
   logic                   adc_on_a_o;
   logic                   adc_oe_b_o;
   logic                   adc_on_b_o;
   logic                   phy_resetn_o;
   logic [`LED_W-1:0]      leds_o;
   logic                   proc_int_o;
   logic [`SET_DATA_W-1:0] rb_data_o;

   // Stimulus table
   logic [1:0]  row_op    [MAX_ROWS];
   logic [7:0]  row_addr  [MAX_ROWS];
   logic [31:0] row_data  [MAX_ROWS];
   logic [1:0]  row_watch [MAX_ROWS];
   int          row_lat   [MAX_ROWS];
   logic [31:0] row_exp   [MAX_ROWS];
   int          n_rows    = 0;
   int          cycle_cnt = 0;

   u2_ctrl_top i_dut (.*);

   initial begin
      dsp_clk = 1'b0;
      forever #4 dsp_clk = ~dsp_clk;
   end

   // Run limit scales with the table
   initial begin
      forever begin
         @(posedge dsp_clk);
         cycle_cnt = cycle_cnt + 1;
         if (cycle_cnt > n_rows * 8 + 50) begin
            $display("Timeout: the stimulus table did not finish in %0d cycles", cycle_cnt);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped by timeout");
         end
      end
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                  $time, what, actual, expected);
         $display("TEST FAILED");
         $fatal(1, "mismatch");
      end
   endtask

   // Pin order: clock 4..0, SERDES 3..0, ADC 3..0, then PHY reset release
   function automatic logic [31:0] pin_word(input logic [4:0] clk, input logic [3:0] ser,
                                            input logic [3:0] adc, input logic phyn);
      return {18'b0, clk, ser, adc, phyn};
   endfunction

   function automatic logic [31:0] observe(input logic [1:0] watch);
      case (watch)
         W_PINS: return {18'b0, clock_ready_o, clk_en_o, clk_sel_o,
                         ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o,
                         adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o, phy_resetn_o};
         W_LEDS:  return {24'b0, leds_o};
         W_INT:   return {31'b0, proc_int_o};
         default: return rb_data_o;
      endcase
   endfunction

   task automatic add_row(input logic [1:0] op, input logic [7:0] addr, input logic [31:0] data,
                          input logic [1:0] watch, input int lat, input logic [31:0] exp);
      row_op[n_rows]    = op;
      row_addr[n_rows]  = addr;
      row_data[n_rows]  = data;
      row_watch[n_rows] = watch;
      row_lat[n_rows]   = lat;
      row_exp[n_rows]   = exp;
      n_rows = n_rows + 1;
   endtask

   // Drive one row, step lat edges, then sample the watched output
   task automatic apply_row(input int idx);
      case (row_op[idx])
         OP_WR: begin
            set_stb_i  = 1'b1;
            set_addr_i = row_addr[idx];
            set_data_i = row_data[idx];
         end
         OP_IRQ:  irq_i = row_data[idx][`IRQ_W-1:0];
         OP_RD:   rb_addr_i = row_addr[idx][`RB_ADDR_W-1:0];
         default: ;
      endcase
      repeat (row_lat[idx]) begin
         @(posedge dsp_clk);
         #1;
         set_stb_i = 1'b0;
      end
      check_equal(observe(row_watch[idx]), row_exp[idx],
                  $sformatf("row %0d op %0d watch %0d", idx, row_op[idx], row_watch[idx]));
   endtask

   ////////////////////////////////////////
   // Table and main sequence
   ////////////////////////////////////////

   initial begin
      arst_n_i         = 1'b0;
      set_stb_i        = 1'b0;
      set_addr_i       = '0;
      set_data_i       = '0;
      irq_i            = '0;
      // Hardware LED word is 8'b10 with these levels
      clk_status_i     = 1'b1;
      serdes_link_up_i = 1'b0;
      sim_mode_i       = 1'b1;
      clock_divider_i  = 4'h6;
      rb_addr_i        = '0;

      // Reset state
      add_row(OP_IDLE, 8'd0, 32'h0, W_PINS, 1, pin_word(5'h00, 4'h0, 4'h0, 1'b1));
      add_row(OP_IDLE, 8'd0, 32'h0, W_LEDS, 1, 32'h0);
      add_row(OP_IDLE, 8'd0, 32'h0, W_INT,  1, 32'h0);
      add_row(OP_IDLE, 8'd0, 32'h0, W_RB,   1, 32'h0);
      // Control pins, only the low bits of each word count
      add_row(OP_WR, SR_CLK, 32'hFFFF_FFF6, W_PINS, 1, pin_word(5'h16, 4'h0, 4'h0, 1'b1));
      add_row(OP_WR, SR_SER, 32'hABCD_000B, W_PINS, 1, pin_word(5'h16, 4'hB, 4'h0, 1'b1));
      add_row(OP_WR, SR_ADC, 32'h0000_000C, W_PINS, 1, pin_word(5'h16, 4'hB, 4'hC, 1'b1));
      add_row(OP_WR, SR_PHY, 32'h0000_0001, W_PINS, 1, pin_word(5'h16, 4'hB, 4'hC, 1'b0));
      add_row(OP_WR, 8'd5,   32'hFFFF_FFFF, W_PINS, 1, pin_word(5'h16, 4'hB, 4'hC, 1'b0));
      add_row(OP_WR, SR_PHY, 32'h0000_0000, W_PINS, 1, pin_word(5'h16, 4'hB, 4'hC, 1'b1));
      // LEDs lag a settings write by two cycles
      add_row(OP_WR,   SR_LED,     32'h0000_00A5, W_LEDS, 1, 32'h00);
      add_row(OP_IDLE, 8'd0,       32'h0,         W_LEDS, 1, 32'hA5);
      add_row(OP_WR,   SR_LED_SRC, 32'h0000_0003, W_LEDS, 1, 32'hA5);
      add_row(OP_IDLE, 8'd0,       32'h0,         W_LEDS, 1, 32'hA6);
      // Line 4 rises while masked off
      add_row(OP_IRQ,  8'd0,         32'h0010, W_INT, 2, 32'h0);
      add_row(OP_RD,   RB_IRQ_PEND,  32'h0,    W_RB,  1, 32'h10);
      add_row(OP_IDLE, 8'd0,         32'h0,    W_INT, 2, 32'h0);
      add_row(OP_WR,   SR_IRQ_MASK,  32'h0010, W_INT, 1, 32'h0);
      add_row(OP_IDLE, 8'd0,         32'h0,    W_INT, 1, 32'h1);
      add_row(OP_RD,   RB_IRQ_MASK,  32'h0,    W_RB,  1, 32'h10);
      add_row(OP_WR,   SR_IRQ_CLEAR, 32'h0010, W_INT, 1, 32'h0);
      // Held line does not pend again
      add_row(OP_RD,   RB_IRQ_PEND,  32'h0,    W_RB,  1, 32'h0);
      add_row(OP_IDLE, 8'd0,         32'h0,    W_INT, 3, 32'h0);
      add_row(OP_IRQ,  8'd0,         32'h0000, W_INT, 1, 32'h0);
      add_row(OP_IRQ,  8'd0,         32'h0011, W_INT, 1, 32'h0);
      add_row(OP_IDLE, 8'd0,         32'h0,    W_INT, 1, 32'h1);
      add_row(OP_RD,   RB_IRQ_PEND,  32'h0,    W_RB,  1, 32'h11);
      add_row(OP_WR,   SR_IRQ_CLEAR, 32'h0010, W_INT, 1, 32'h0);
      add_row(OP_RD,   RB_IRQ_PEND,  32'h0,    W_RB,  1, 32'h01);
      // Readback map
      add_row(OP_RD, RB_CLK,     32'h0, W_RB, 1, 32'h16);
      add_row(OP_RD, RB_SER,     32'h0, W_RB, 1, 32'hB);
      add_row(OP_RD, RB_ADC,     32'h0, W_RB, 1, 32'hC);
      add_row(OP_RD, RB_LED_SW,  32'h0, W_RB, 1, 32'hA5);
      add_row(OP_RD, RB_PHY,     32'h0, W_RB, 1, 32'h0);
      // PHY word shows up one cycle behind the register
      add_row(OP_WR,   SR_PHY,   32'h1, W_RB, 1, 32'h0);
      add_row(OP_IDLE, 8'd0,     32'h0, W_RB, 1, 32'h1);
      add_row(OP_RD, RB_LED_SRC, 32'h0, W_RB, 1, 32'h3);
      add_row(OP_RD, RB_SYS,     32'h0, W_RB, 1, 32'h8000_0006);
      add_row(OP_RD, 8'd5,       32'h0, W_RB, 1, 32'h0);
      add_row(OP_RD, 8'd15,      32'h0, W_RB, 1, 32'h0);
      add_row(OP_RD, 8'd7,       32'h0, W_RB, 1, 32'h0);

      repeat (3) @(posedge dsp_clk);
      #1;
      arst_n_i = 1'b1;
      for (int i = 0; i < n_rows; i++) begin
         apply_row(i);
      end
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== u2_ctrl.f ====
+incdir+include
hw/u2_ctrl_pkg.sv
hw/setting_bank.sv
hw/irq_controller.sv
hw/front_panel_status.sv
hw/u2_ctrl_top.sv
dv/u2_ctrl_tb.sv
